// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_gige_lb_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := TESTS PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN):
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
hdl/gige_lb_pkg.sv
hdl/lb_decode.sv
hdl/lb_regs.sv
hdl/trace_capture.sv
hdl/lb_read_mux.sv
hdl/status_leds.sv
hdl/gige_lb_top.sv
verif/tb_gige_lb_top.sv

// File: hdl/gige_lb_pkg.sv
// ----------------------------
// Local-bus widths and region map
// Register offsets and identifier
// Decoded command, trace status and LED control types
// ----------------------------
`default_nettype none

package gige_lb_pkg;

   // Bus widths
   localparam int LB_ADDR_W   = 24;
   localparam int LB_DATA_W   = 32;
   // Offset is everything below the region nibble
   localparam int LB_OFFSET_W = LB_ADDR_W - 4;

   // Returned by REG_ID
   localparam logic [LB_DATA_W-1:0] ID_VALUE = 32'h6C62_0001;

   // ----------------------------
   // Address regions, from addr[23:20]
   // ----------------------------
   typedef enum logic [1:0] {
      REGION_REGS  = 2'd0,
      REGION_TRACE = 2'd1,
      REGION_NONE  = 2'd2
   } lb_region_e;

   // Register offsets inside REGION_REGS
   typedef enum logic [LB_OFFSET_W-1:0] {
      REG_ID        = 0,
      REG_SCRATCH   = 1,
      REG_STATUS    = 2,
      REG_TRACE_CTL = 3,
      REG_LED_CTL   = 4
   } lb_reg_e;

   // ----------------------------
   // Decoded bus command
   // ----------------------------
   typedef struct packed {
      logic                   valid;
      logic                   rnw;
      lb_region_e             region;
      logic [LB_OFFSET_W-1:0] offset;
      logic [LB_DATA_W-1:0]   wdata;
   } lb_cmd_t;

   // Laid out as the REG_TRACE_CTL read word
   typedef struct packed {
      logic        full;
      logic        armed;
      logic        running;
      logic [28:0] ptr;
   } trace_status_t;

   // Bit 4 enable, bits 3:0 pattern
   typedef struct packed {
      logic       en;
      logic [3:0] pattern;
   } led_ctl_t;

endpackage

`default_nettype wire

// File: hdl/gige_lb_top.sv
// ----------------------------
// Local-bus subsystem top
// Decode, registers, trace, read mux, LEDs
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module gige_lb_top #(
   parameter int TRACE_AW = 10,
   parameter int TRACE_DW = 16,
   parameter int TRACE_TW = 16,
   parameter int HB_BIT   = 26
) (
   input  wire                                lb_clk,
   input  wire                                i_rst_n,
   // Bus strobe from the Ethernet bridge
   input  wire                                i_lb_valid,
   input  wire                                i_lb_rnw,
   input  wire  [gige_lb_pkg::LB_ADDR_W-1:0]  i_lb_addr,
   input  wire  [gige_lb_pkg::LB_DATA_W-1:0]  i_lb_wdata,
   // Status levels
   input  wire                                i_gt_locked,
   input  wire                                i_an_done,
   input  wire                                i_rx_mon,
   // Debug word to trace
   input  wire                                i_trace_start,
   input  wire  [TRACE_DW-1:0]                i_trace_data,
   output logic [gige_lb_pkg::LB_DATA_W-1:0]  o_lb_rdata,
   output logic [3:0]                         o_led
);

   gige_lb_pkg::lb_cmd_t              cmd;
   gige_lb_pkg::trace_status_t        trace_status;
   gige_lb_pkg::led_ctl_t             led_ctl;
   logic                              trace_arm;
   logic [gige_lb_pkg::LB_DATA_W-1:0] reg_rdata;
   logic [gige_lb_pkg::LB_DATA_W-1:0] trace_rdata;

   // ----------------------------
   // Decode
   // ----------------------------
   lb_decode i_lb_decode (
      .lb_clk     (lb_clk),
      .i_rst_n    (i_rst_n),
      .i_lb_valid (i_lb_valid),
      .i_lb_rnw   (i_lb_rnw),
      .i_lb_addr  (i_lb_addr),
      .i_lb_wdata (i_lb_wdata),
      .o_cmd      (cmd)
   );

   // ----------------------------
   // Execute
   // ----------------------------
   lb_regs i_lb_regs (
      .lb_clk         (lb_clk),
      .i_rst_n        (i_rst_n),
      .i_cmd          (cmd),
      .i_gt_locked    (i_gt_locked),
      .i_an_done      (i_an_done),
      .i_rx_mon       (i_rx_mon),
      .i_trace_status (trace_status),
      .o_rdata        (reg_rdata),
      .o_trace_arm    (trace_arm),
      .o_led_ctl      (led_ctl)
   );

   trace_capture #(
      .TRACE_AW (TRACE_AW),
      .TRACE_DW (TRACE_DW),
      .TRACE_TW (TRACE_TW)
   ) i_trace_capture (
      .lb_clk        (lb_clk),
      .i_rst_n       (i_rst_n),
      .i_cmd         (cmd),
      .i_trace_arm   (trace_arm),
      .i_trace_start (i_trace_start),
      .i_trace_data  (i_trace_data),
      .o_rdata       (trace_rdata),
      .o_status      (trace_status)
   );

   // ----------------------------
   // Result
   // ----------------------------
   lb_read_mux i_lb_read_mux (
      .lb_clk        (lb_clk),
      .i_rst_n       (i_rst_n),
      .i_cmd         (cmd),
      .i_reg_rdata   (reg_rdata),
      .i_trace_rdata (trace_rdata),
      .o_lb_rdata    (o_lb_rdata)
   );

   status_leds #(
      .HB_BIT (HB_BIT)
   ) i_status_leds (
      .lb_clk      (lb_clk),
      .i_rst_n     (i_rst_n),
      .i_cmd       (cmd),
      .i_gt_locked (i_gt_locked),
      .i_an_done   (i_an_done),
      .i_led_ctl   (led_ctl),
      .o_led       (o_led)
   );

endmodule

`default_nettype wire

// File: hdl/lb_decode.sv
// ----------------------------
// Local-bus strobe decode
// Registers one strobe into a decoded command
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module lb_decode (
   input  wire                                lb_clk,
   input  wire                                i_rst_n,
   input  wire                                i_lb_valid,
   input  wire                                i_lb_rnw,
   input  wire  [gige_lb_pkg::LB_ADDR_W-1:0]  i_lb_addr,
   input  wire  [gige_lb_pkg::LB_DATA_W-1:0]  i_lb_wdata,
   output gige_lb_pkg::lb_cmd_t               o_cmd
);

   gige_lb_pkg::lb_region_e region;

   // Top nibble picks the region
   always_comb begin
      case (i_lb_addr[gige_lb_pkg::LB_ADDR_W-1 -: 4])
         4'd0:    region = gige_lb_pkg::REGION_REGS;
         4'd1:    region = gige_lb_pkg::REGION_TRACE;
         default: region = gige_lb_pkg::REGION_NONE;
      endcase
   end

   // Strobe flag, cleared on reset
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         o_cmd.valid <= 1'b0;
      end else begin
         o_cmd.valid <= i_lb_valid;
      end
   end

   // Command payload, captured every cycle
   always_ff @(posedge lb_clk) begin
      o_cmd.rnw    <= i_lb_rnw;
      o_cmd.region <= region;
      o_cmd.offset <= i_lb_addr[gige_lb_pkg::LB_OFFSET_W-1:0];
      o_cmd.wdata  <= i_lb_wdata;
   end

   // No command without a strobe the cycle before
   a_no_spurious_cmd : assert property (
      @(posedge lb_clk) disable iff (!i_rst_n)
      !i_lb_valid |=> !o_cmd.valid
   ) else $error("lb_decode: command valid without strobe");

endmodule

`default_nettype wire

// File: hdl/lb_read_mux.sv
// ----------------------------
// Read data return mux
// Picks the word of the region read two cycles back
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module lb_read_mux (
   input  wire                                 lb_clk,
   input  wire                                 i_rst_n,
   input  gige_lb_pkg::lb_cmd_t                i_cmd,
   input  wire  [gige_lb_pkg::LB_DATA_W-1:0]   i_reg_rdata,
   input  wire  [gige_lb_pkg::LB_DATA_W-1:0]   i_trace_rdata,
   output logic [gige_lb_pkg::LB_DATA_W-1:0]   o_lb_rdata
);

   logic                    pending_q;
   gige_lb_pkg::lb_region_e region_q;

   // Read in flight, lines up with the execute read words
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         pending_q <= 1'b0;
      end else begin
         pending_q <= i_cmd.valid && i_cmd.rnw;
      end
   end

   always_ff @(posedge lb_clk) begin
      region_q <= i_cmd.region;
   end

   // Zero outside a result cycle
   always_comb begin
      o_lb_rdata = '0;
      if (pending_q) begin
         case (region_q)
            gige_lb_pkg::REGION_REGS:  o_lb_rdata = i_reg_rdata;
            gige_lb_pkg::REGION_TRACE: o_lb_rdata = i_trace_rdata;
            default:                   o_lb_rdata = '0;
         endcase
      end
   end

   a_none_reads_zero : assert property (
      @(posedge lb_clk) disable iff (!i_rst_n)
      (pending_q && (region_q == gige_lb_pkg::REGION_NONE)) |-> (o_lb_rdata == '0)
   ) else $error("lb_read_mux: nonzero data for unmapped region");

endmodule

`default_nettype wire

// File: hdl/lb_regs.sv
// ----------------------------
// Control and status registers
// Scratch, status, trace control, LED control
// Registered read word, trace arm pulse
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module lb_regs (
   input  wire                                 lb_clk,
   input  wire                                 i_rst_n,
   input  gige_lb_pkg::lb_cmd_t                i_cmd,
   input  wire                                 i_gt_locked,
   input  wire                                 i_an_done,
   input  wire                                 i_rx_mon,
   input  gige_lb_pkg::trace_status_t          i_trace_status,
   output logic [gige_lb_pkg::LB_DATA_W-1:0]   o_rdata,
   output logic                                o_trace_arm,
   output gige_lb_pkg::led_ctl_t               o_led_ctl
);

   gige_lb_pkg::lb_reg_e             reg_sel;
   logic                             hit;
   logic                             wr_en;
   logic                             rd_en;
   logic [gige_lb_pkg::LB_DATA_W-1:0] scratch;
   logic [gige_lb_pkg::LB_DATA_W-1:0] rd_word;

   // Only commands into the register region
   assign hit     = i_cmd.valid && (i_cmd.region == gige_lb_pkg::REGION_REGS);
   assign wr_en   = hit && !i_cmd.rnw;
   assign rd_en   = hit && i_cmd.rnw;
   // Offset acts as the register opcode
   assign reg_sel = gige_lb_pkg::lb_reg_e'(i_cmd.offset);

   // ----------------------------
   // Write side
   // ----------------------------
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         o_led_ctl   <= '0;
         o_trace_arm <= 1'b0;
      end else begin
         if (wr_en && (reg_sel == gige_lb_pkg::REG_LED_CTL)) begin
            o_led_ctl <= gige_lb_pkg::led_ctl_t'(i_cmd.wdata[4:0]);
         end
         // Back-to-back arms merge into one pulse
         o_trace_arm <= wr_en && (reg_sel == gige_lb_pkg::REG_TRACE_CTL) && !o_trace_arm;
      end
   end

   // Scratch holds data only
   always_ff @(posedge lb_clk) begin
      if (wr_en && (reg_sel == gige_lb_pkg::REG_SCRATCH)) begin
         scratch <= i_cmd.wdata;
      end
   end

   // ----------------------------
   // Read side
   // ----------------------------
   always_comb begin
      rd_word = '0;
      case (reg_sel)
         gige_lb_pkg::REG_ID:        rd_word = gige_lb_pkg::ID_VALUE;
         gige_lb_pkg::REG_SCRATCH:   rd_word = scratch;
         gige_lb_pkg::REG_STATUS:    rd_word = 32'({i_gt_locked, i_rx_mon, i_an_done});
         gige_lb_pkg::REG_TRACE_CTL: rd_word = i_trace_status;
         gige_lb_pkg::REG_LED_CTL:   rd_word = 32'(o_led_ctl);
         // Unmapped offsets
         default:                    rd_word = '0;
      endcase
   end

   // Read word ready the cycle after the command
   always_ff @(posedge lb_clk) begin
      if (rd_en) begin
         o_rdata <= rd_word;
      end
   end

   // Arm never lasts more than one cycle
   a_arm_pulse : assert property (
      @(posedge lb_clk) disable iff (!i_rst_n)
      o_trace_arm |=> !o_trace_arm
   ) else $error("lb_regs: trace arm wider than one cycle");

endmodule

`default_nettype wire

// File: hdl/status_leds.sv
// ----------------------------
// Status LEDs
// Heartbeat, read activity, software override
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module status_leds #(
   parameter int HB_BIT = 26
) (
   input  wire                     lb_clk,
   input  wire                     i_rst_n,
   input  gige_lb_pkg::lb_cmd_t    i_cmd,
   input  wire                     i_gt_locked,
   input  wire                     i_an_done,
   input  gige_lb_pkg::led_ctl_t   i_led_ctl,
   output logic [3:0]              o_led
);

   logic [HB_BIT:0] hb_cnt;
   logic            rd_act;
   logic [3:0]      led_status;

   // Read command this cycle, shows on LED next cycle
   assign rd_act     = i_cmd.valid && i_cmd.rnw;
   // Lock, heartbeat, read activity, autoneg done
   assign led_status = {i_gt_locked, hb_cnt[HB_BIT], rd_act, i_an_done};

   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         hb_cnt <= '0;
         o_led  <= '0;
      end else begin
         hb_cnt <= hb_cnt + (HB_BIT + 1)'(1);
         o_led  <= i_led_ctl.en ? i_led_ctl.pattern : led_status;
      end
   end

endmodule

`default_nettype wire

// File: hdl/trace_capture.sv
// ----------------------------
// Run-length trace capture
// Idle, armed, running, full sequencing
// Trace memory with bus readback
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module trace_capture #(
   parameter int TRACE_AW = 10,
   parameter int TRACE_DW = 16,
   parameter int TRACE_TW = 16
) (
   input  wire                                lb_clk,
   input  wire                                i_rst_n,
   input  gige_lb_pkg::lb_cmd_t               i_cmd,
   input  wire                                i_trace_arm,
   input  wire                                i_trace_start,
   input  wire  [TRACE_DW-1:0]                i_trace_data,
   output logic [gige_lb_pkg::LB_DATA_W-1:0]  o_rdata,
   output gige_lb_pkg::trace_status_t         o_status
);

   // Entry is {run count, data}
   localparam int ENTRY_W = TRACE_TW + TRACE_DW;

   typedef enum logic [1:0] {
      TR_IDLE,
      TR_ARMED,
      TR_RUNNING,
      TR_FULL
   } trace_state_e;

   trace_state_e        state;
   logic                first_q;
   logic [TRACE_AW-1:0] ptr;
   logic [TRACE_DW-1:0] held;
   logic [TRACE_TW-1:0] count;
   logic [ENTRY_W-1:0]  mem [2**TRACE_AW];
   logic                run_ext;
   logic                mem_we;
   logic                bus_rd;

   // Same data and count not saturated
   assign run_ext = (i_trace_data == held) && (count != '1);
   // Run ended, flush one entry
   assign mem_we  = (state == TR_RUNNING) && !first_q && !run_ext && !i_trace_arm;
   assign bus_rd  = i_cmd.valid && i_cmd.rnw &&
                    (i_cmd.region == gige_lb_pkg::REGION_TRACE);

   // ----------------------------
   // Capture FSM
   // ----------------------------
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         state   <= TR_IDLE;
         ptr     <= '0;
         first_q <= 1'b0;
      end else if (i_trace_arm) begin
         // Re-arm from any state
         state   <= TR_ARMED;
         ptr     <= '0;
         first_q <= 1'b0;
      end else begin
         case (state)
            TR_ARMED: begin
               if (i_trace_start) begin
                  state   <= TR_RUNNING;
                  first_q <= 1'b1;
               end
            end
            TR_RUNNING: begin
               first_q <= 1'b0;
               if (mem_we) begin
                  // Last slot written, hold pointer there
                  if (ptr == '1) state <= TR_FULL;
                  else           ptr   <= ptr + TRACE_AW'(1);
               end
            end
            default: ;
         endcase
      end
   end

   // Held value and run count
   always_ff @(posedge lb_clk) begin
      if (state == TR_RUNNING) begin
         if (first_q || !run_ext) begin
            held  <= i_trace_data;
            count <= TRACE_TW'(1);
         end else begin
            count <= count + TRACE_TW'(1);
         end
      end
   end

   // ----------------------------
   // Trace memory
   // ----------------------------
   always_ff @(posedge lb_clk) begin
      if (mem_we) begin
         mem[ptr] <= {count, held};
      end
      // Synchronous readback, zero-extended
      if (bus_rd) begin
         o_rdata              <= '0;
         o_rdata[ENTRY_W-1:0] <= mem[i_cmd.offset[TRACE_AW-1:0]];
      end
   end

   always_comb begin
      o_status.full    = (state == TR_FULL);
      o_status.armed   = (state == TR_ARMED);
      o_status.running = (state == TR_RUNNING);
      o_status.ptr     = 29'(ptr);
   end

   a_no_write_full : assert property (
      @(posedge lb_clk) disable iff (!i_rst_n)
      mem_we |-> (state != TR_FULL)
   ) else $error("trace_capture: memory write while full");

endmodule

`default_nettype wire

// File: verif/tb_gige_lb_top.sv
// ------------------------------
// Testbench for the local-bus subsystem
// Clock, reset, bus write and read tasks, value check
// Directed tests for registers, pipelined reads, status, trace, LEDs
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_gige_lb_top;

   localparam int TRACE_AW = 3;
   localparam int TRACE_DW = 16;
   localparam int TRACE_TW = 16;
   localparam int HB_BIT   = 4;
   // Poll limit for every wait loop
   localparam int WAIT_MAX = 64;

   // Register region at top nibble 0
   localparam logic [23:0] A_ID        = 24'h00_0000;
   localparam logic [23:0] A_SCRATCH   = 24'h00_0001;
   localparam logic [23:0] A_STATUS    = 24'h00_0002;
   localparam logic [23:0] A_TRACE_CTL = 24'h00_0003;
   localparam logic [23:0] A_LED_CTL   = 24'h00_0004;
   localparam logic [23:0] A_UNMAPPED  = 24'h00_0007;
   // Trace memory at top nibble 1
   localparam logic [23:0] A_TRACE_MEM = 24'h10_0000;
   // Outside any region
   localparam logic [23:0] A_NONE      = 24'h20_0001;

   logic                lb_clk;
   logic                rst_n;
   logic                lb_valid;
   logic                lb_rnw;
   logic [23:0]         lb_addr;
   logic [31:0]         lb_wdata;
   logic                gt_locked;
   logic                an_done;
   logic                rx_mon;
   logic                trace_start;
   logic [TRACE_DW-1:0] trace_data;
   logic [31:0]         lb_rdata;
   logic [3:0]          led;
   integer              seed;

   gige_lb_top #(
      .TRACE_AW (TRACE_AW),
      .TRACE_DW (TRACE_DW),
      .TRACE_TW (TRACE_TW),
      .HB_BIT   (HB_BIT)
   ) i_gige_lb_top (
      .lb_clk        (lb_clk),
      .i_rst_n       (rst_n),
      .i_lb_valid    (lb_valid),
      .i_lb_rnw      (lb_rnw),
      .i_lb_addr     (lb_addr),
      .i_lb_wdata    (lb_wdata),
      .i_gt_locked   (gt_locked),
      .i_an_done     (an_done),
      .i_rx_mon      (rx_mon),
      .i_trace_start (trace_start),
      .i_trace_data  (trace_data),
      .o_lb_rdata    (lb_rdata),
      .o_led         (led)
   );

   // 40 ns clock
   always #20 lb_clk = ~lb_clk;

   // ------------------------------
   // Helpers
   // ------------------------------
   // Every step lands 2 ns after a rising edge
   task automatic next_cycle();
      @(posedge lb_clk);
      #2;
   endtask

   task automatic abort_run(input string what);
      $display("%s at time %0t", what, $time);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("Error: time %0t: %s: got 0x%08h, expected 0x%08h",
                  $time, what, actual, expected);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // One write strobe
   task automatic bus_write(input logic [23:0] addr, input logic [31:0] data);
      lb_valid = 1'b1;
      lb_rnw   = 1'b0;
      lb_addr  = addr;
      lb_wdata = data;
      next_cycle();
      lb_valid = 1'b0;
   endtask

   // One read strobe with the result two cycles later
   task automatic bus_read(input logic [23:0] addr, output logic [31:0] data);
      lb_valid = 1'b1;
      lb_rnw   = 1'b1;
      lb_addr  = addr;
      next_cycle();
      lb_valid = 1'b0;
      next_cycle();
      data = lb_rdata;
   endtask

   task automatic read_check(input logic [23:0] addr, input logic [31:0] expected,
                             input string what);
      logic [31:0] rd;
      bus_read(addr, rd);
      check_value(rd, expected, what);
   endtask

   // Poll one REG_TRACE_CTL flag bit
   task automatic wait_trace_flag(input int flag_bit, input string what);
      logic [31:0] st;
      int          polls;
      st    = '0;
      polls = 0;
      while (!st[flag_bit] && polls < WAIT_MAX) begin
         bus_read(A_TRACE_CTL, st);
         polls++;
      end
      if (!st[flag_bit]) abort_run({"Timeout waiting for trace ", what});
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic test_registers();
      logic [31:0] wd;
      read_check(A_ID, gige_lb_pkg::ID_VALUE, "REG_ID");
      // Read strobed the cycle right after the write
      repeat (4) begin
         wd = $random(seed);
         bus_write(A_SCRATCH, wd);
         read_check(A_SCRATCH, wd, "REG_SCRATCH after write");
      end
      // Write to read-only REG_ID is ignored
      bus_write(A_ID, ~gige_lb_pkg::ID_VALUE);
      read_check(A_ID, gige_lb_pkg::ID_VALUE, "REG_ID after write");
      read_check(A_NONE, 32'h0, "REGION_NONE read");
      read_check(24'hF0_0002, 32'h0, "REGION_NONE high nibble read");
      read_check(A_UNMAPPED, 32'h0, "unmapped offset read");
   endtask

   task automatic test_pipelined();
      logic [31:0] wd;
      logic [31:0] status_exp;
      wd = $random(seed);
      bus_write(A_SCRATCH, wd);
      // Status word distinct from an idle cycle
      gt_locked  = 1'b1;
      rx_mon     = 1'b0;
      an_done    = 1'b1;
      status_exp = {29'd0, gt_locked, rx_mon, an_done};
      // Three strobes back to back
      lb_valid = 1'b1;
      lb_rnw   = 1'b1;
      lb_addr  = A_SCRATCH;
      next_cycle();
      lb_addr  = A_ID;
      next_cycle();
      lb_addr  = A_STATUS;
      check_value(lb_rdata, wd, "pipelined REG_SCRATCH");
      next_cycle();
      lb_valid = 1'b0;
      check_value(lb_rdata, gige_lb_pkg::ID_VALUE, "pipelined REG_ID");
      next_cycle();
      check_value(lb_rdata, status_exp, "pipelined REG_STATUS");
      next_cycle();
      // No result pending
      check_value(lb_rdata, 32'h0, "read data idle");
   endtask

   task automatic test_status();
      logic [31:0] rnd;
      repeat (6) begin
         rnd       = $random(seed);
         gt_locked = rnd[0];
         an_done   = rnd[1];
         rx_mon    = rnd[2];
         next_cycle();
         check_value({31'd0, led[3]}, {31'd0, gt_locked}, "lock LED");
         check_value({31'd0, led[0]}, {31'd0, an_done}, "autoneg LED");
         read_check(A_STATUS, {29'd0, gt_locked, rx_mon, an_done}, "REG_STATUS");
      end
   endtask

   task automatic test_trace();
      logic [TRACE_DW-1:0] samples[$];
      logic [31:0]         expected[$];
      int                  lens[10];
      logic [31:0]         rnd;
      logic [31:0]         rd;
      logic [TRACE_DW-1:0] val;
      logic [TRACE_DW-1:0] prev;
      logic [TRACE_DW-1:0] held;
      logic [TRACE_TW-1:0] count;
      int                  depth;
      depth = 2 ** TRACE_AW;
      lens  = '{3, 1, 4, 2, 1, 5, 2, 3, 1, 2};
      prev  = '0;
      // Runs of varying length where neighbouring runs differ
      for (int i = 0; i < 10; i++) begin
         rnd = $random(seed);
         val = rnd[TRACE_DW-1:0];
         if (i > 0 && val == prev) val = val ^ 16'h0001;
         for (int j = 0; j < lens[i]; j++) samples.push_back(val);
         prev = val;
      end
      // Run-length model with entries of {count, data}
      held  = samples[0];
      count = 16'd1;
      for (int i = 1; i < samples.size() && expected.size() < depth; i++) begin
         if (samples[i] == held && count != '1) begin
            count++;
         end else begin
            expected.push_back({count, held});
            held  = samples[i];
            count = 16'd1;
         end
      end

      bus_write(A_TRACE_CTL, 32'h0);
      wait_trace_flag(30, "armed");
      trace_start = 1'b1;
      next_cycle();
      trace_start = 1'b0;
      // First captured cycle follows the start pulse
      for (int i = 0; i < samples.size(); i++) begin
         trace_data = samples[i];
         next_cycle();
      end
      wait_trace_flag(31, "full");
      read_check(A_TRACE_CTL, {3'b100, 29'(depth - 1)}, "trace status full");

      for (int i = 0; i < depth; i++) begin
         bus_read(A_TRACE_MEM | 24'(i), rd);
         check_value(rd, expected[i], $sformatf("trace entry %0d", i));
      end

      // Pointer holds while data keeps changing
      repeat (5) begin
         trace_data = ~trace_data;
         next_cycle();
      end
      read_check(A_TRACE_CTL, {3'b100, 29'(depth - 1)}, "trace status still full");

      bus_write(A_TRACE_CTL, $random(seed));
      wait_trace_flag(30, "re-armed");
      read_check(A_TRACE_CTL, 32'h4000_0000, "trace status after re-arm");
   endtask

   task automatic test_leds();
      logic        hb;
      int          polls;
      logic [31:0] rnd;
      logic [31:0] rd;
      logic [3:0]  pat;
      // Heartbeat bit flips every 2**HB_BIT cycles
      hb    = led[2];
      polls = 0;
      while (led[2] == hb && polls < 2 ** HB_BIT + 2) begin
         next_cycle();
         polls++;
      end
      if (led[2] == hb) abort_run("Heartbeat LED did not toggle");

      bus_read(A_ID, rd);
      check_value({31'd0, led[1]}, 32'd1, "read activity LED");
      next_cycle();
      check_value({31'd0, led[1]}, 32'd0, "read activity LED idle");

      // Software override
      rnd = $random(seed);
      pat = rnd[3:0];
      bus_write(A_LED_CTL, {27'd0, 1'b1, pat});
      next_cycle();
      next_cycle();
      check_value({28'd0, led}, {28'd0, pat}, "LED override");
      read_check(A_LED_CTL, {27'd0, 1'b1, pat}, "REG_LED_CTL readback");
      check_value({28'd0, led}, {28'd0, pat}, "LED override held");

      bus_write(A_LED_CTL, 32'h0);
      next_cycle();
      next_cycle();
      check_value({30'd0, led[3], led[0]}, {30'd0, gt_locked, an_done}, "LED status view");
      check_value({31'd0, led[1]}, 32'd0, "read activity after override");
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      seed        = 90668;
      lb_clk      = 1'b0;
      rst_n       = 1'b0;
      lb_valid    = 1'b0;
      lb_rnw      = 1'b0;
      lb_addr     = '0;
      lb_wdata    = '0;
      gt_locked   = 1'b0;
      an_done     = 1'b0;
      rx_mon      = 1'b0;
      trace_start = 1'b0;
      trace_data  = '0;
      repeat (2) @(posedge lb_clk);
      #2;
      rst_n = 1'b1;
      check_value(lb_rdata, 32'h0, "read data after reset");
      check_value({28'd0, led}, 32'h0, "LEDs after reset");

      test_registers();
      test_pipelined();
      test_status();
      test_trace();
      test_leds();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
